// File: logic/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Load/store unit sizes
////////////////////////////////////////////////////////////////////////////

// Instruction tag carried from execute to write-back
`define LSU_ITAG_W 3

// Data path and address width
`define LSU_WORD_W 32

// Byte lanes per data word
`define LSU_BE_W 4

// Beat and response counters, at most two beats per access
`define LSU_CNT_W 2

`endif

// File: logic/lsu_pkg.sv
`include "lsu_defs.svh"

package lsu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Access size
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        LS_B = 2'b00,
        LS_H = 2'b01,
        LS_W = 2'b10
    } ls_size_e;

    // Beat / response counter
    typedef logic [`LSU_CNT_W-1:0] lsu_cnt_t;

    ////////////////////////////////////////////////////////////////////////////
    // Request from execute stage
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                   w_en;
        logic [`LSU_WORD_W-1:0] addr_base;
        logic [`LSU_WORD_W-1:0] addr_offset;
        ls_size_e               size;
        logic                   sgn;
        logic [`LSU_WORD_W-1:0] w_data;
        logic [`LSU_ITAG_W-1:0] itag;
    } lsu_req_t;

    // Request after address generation
    typedef struct packed {
        logic                   w_en;
        logic [`LSU_WORD_W-1:0] addr;
        logic [1:0]             byte_off;
        ls_size_e               size;
        logic                   sgn;
        logic                   misalign;
        logic [`LSU_WORD_W-1:0] w_data;
        logic [`LSU_ITAG_W-1:0] itag;
    } lsu_dec_t;

    ////////////////////////////////////////////////////////////////////////////
    // Data memory beat and write-back
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [`LSU_WORD_W-1:0] addr;
        logic                   w_en;
        logic [`LSU_BE_W-1:0]   be;
        logic [`LSU_WORD_W-1:0] w_data;
    } dmem_req_t;

    typedef struct packed {
        logic [`LSU_WORD_W-1:0] data;
        logic [`LSU_ITAG_W-1:0] itag;
    } lsu_wb_t;

endpackage

// File: logic/lsu_addr_gen.sv
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_addr_gen (
    input  lsu_pkg::lsu_req_t req_i,
    output lsu_pkg::lsu_dec_t dec_o
);
    import lsu_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Effective address
    ////////////////////////////////////////////////////////////////////////////
    logic [`LSU_WORD_W-1:0] eff_addr;
    logic [1:0]             byte_off;
    logic                   w_misalign;
    logic                   h_misalign;

    // Base plus offset, no overflow detection
    assign eff_addr = req_i.addr_base + req_i.addr_offset;
    assign byte_off = eff_addr[1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Misalignment
    ////////////////////////////////////////////////////////////////////////////

    // Word must sit at offset 0
    assign w_misalign = (req_i.size == LS_W) && (byte_off != 2'b00);
    // Half-word only spills over at offset 3
    assign h_misalign = (req_i.size == LS_H) && (byte_off == 2'b11);
    // Bytes never cross a word

    ////////////////////////////////////////////////////////////////////////////
    // Decoded request
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        dec_o.w_en     = req_i.w_en;
        // Word-aligned address of the first beat
        dec_o.addr     = {eff_addr[`LSU_WORD_W-1:2], 2'b00};
        dec_o.byte_off = byte_off;
        dec_o.size     = req_i.size;
        dec_o.sgn      = req_i.sgn;
        dec_o.misalign = w_misalign | h_misalign;
        dec_o.w_data   = req_i.w_data;
        dec_o.itag     = req_i.itag;
    end

endmodule

// File: logic/lsu_req_regs.sv
`timescale 1ns/100ps

module lsu_req_regs (
    input  logic              clk_i,
    input  lsu_pkg::lsu_dec_t dec_i,
    input  logic              load_issue_i,
    input  logic              load_resp_i,
    input  logic              accept_i,
    output lsu_pkg::lsu_dec_t issue_o,
    output lsu_pkg::lsu_dec_t resp_o
);
    import lsu_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Slot storage
    ////////////////////////////////////////////////////////////////////////////

    // Fields of the operation whose beats are being issued
    lsu_dec_t issue_q;
    // Fields of the operation whose responses are awaited
    lsu_dec_t resp_q;

    ////////////////////////////////////////////////////////////////////////////
    // Issue slot
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        // New operation taken from execute
        if (accept_i) begin
            issue_q <= dec_i;
        end
    end

    // First beat goes out in the accept cycle
    // Slot is not written until the following edge
    assign issue_o = accept_i ? dec_i : issue_q;

    ////////////////////////////////////////////////////////////////////////////
    // Response slot
    ////////////////////////////////////////////////////////////////////////////

    // Two sources
    //   load_resp_i  : all beats issued in the accept cycle, take incoming
    //   load_issue_i : last beat issued later, take the issue slot
    always_ff @(posedge clk_i) begin
        if (load_resp_i) begin
            resp_q <= dec_i;
        end
        else if (load_issue_i) begin
            resp_q <= issue_q;
        end
    end

    // Stays put until the final response of this op
    // Older op is already done by the time it changes
    assign resp_o = resp_q;

endmodule

// File: logic/lsu_store_align.sv
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_store_align (
    input  lsu_pkg::lsu_dec_t  issue_i,
    input  logic               second_beat_i,
    output lsu_pkg::dmem_req_t dmem_req_o
);
    import lsu_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Two-word window
    ////////////////////////////////////////////////////////////////////////////

    // Low half is the first beat, high half the second
    logic [2*`LSU_WORD_W-1:0] data_win;
    logic [2*`LSU_BE_W-1:0]   be_win;
    logic [`LSU_BE_W-1:0]     be_base;
    logic [4:0]               bit_shift;

    // Byte offset in bits
    assign bit_shift = {issue_i.byte_off, 3'b000};

    // Write data moved up to its byte lane
    assign data_win = {{`LSU_WORD_W{1'b0}}, issue_i.w_data} << bit_shift;

    ////////////////////////////////////////////////////////////////////////////
    // Byte enables
    ////////////////////////////////////////////////////////////////////////////

    // Lanes touched at offset 0
    always_comb begin
        case (issue_i.size)
            LS_B:    be_base = 4'b0001;
            LS_H:    be_base = 4'b0011;
            LS_W:    be_base = 4'b1111;
            default: be_base = 4'b0000;
        endcase
    end

    // Shift into the window, spill lands in the upper word
    // e.g. word at offset 1 -> 1110 then 0001
    assign be_win = {{`LSU_BE_W{1'b0}}, be_base} << issue_i.byte_off;

    ////////////////////////////////////////////////////////////////////////////
    // Beat select
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        dmem_req_o.w_en = issue_i.w_en;
        if (second_beat_i) begin
            // Next word up
            dmem_req_o.addr   = issue_i.addr + `LSU_WORD_W'(4);
            dmem_req_o.be     = be_win[2*`LSU_BE_W-1:`LSU_BE_W];
            dmem_req_o.w_data = data_win[2*`LSU_WORD_W-1:`LSU_WORD_W];
        end
        else begin
            // Aligned word, or first half of a split access
            dmem_req_o.addr   = issue_i.addr;
            dmem_req_o.be     = be_win[`LSU_BE_W-1:0];
            dmem_req_o.w_data = data_win[`LSU_WORD_W-1:0];
        end
    end

endmodule

// File: logic/lsu_load_align.sv
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_load_align (
    input  logic                   clk_i,
    input  lsu_pkg::lsu_dec_t      resp_slot_i,
    input  logic                   dmem_resp_vld_i,
    input  logic [`LSU_WORD_W-1:0] dmem_resp_data_i,
    output lsu_pkg::lsu_wb_t       wb_o
);
    import lsu_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Previous response word
    ////////////////////////////////////////////////////////////////////////////
    logic [`LSU_WORD_W-1:0] resp_data_q;

    // Holds the low word of a split load
    always_ff @(posedge clk_i) begin
        if (dmem_resp_vld_i) begin
            resp_data_q <= dmem_resp_data_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Merge and extract
    ////////////////////////////////////////////////////////////////////////////
    logic [2*`LSU_WORD_W-1:0] data_win;
    logic [2*`LSU_WORD_W-1:0] data_shft;
    logic [`LSU_WORD_W-1:0]   data_algn;

    // Split access -> current word on top of the previous one
    // Aligned access uses the current word only
    assign data_win = resp_slot_i.misalign ?
                      {dmem_resp_data_i, resp_data_q} :
                      {{`LSU_WORD_W{1'b0}}, dmem_resp_data_i};

    // Addressed byte down to lane 0
    assign data_shft = data_win >> {resp_slot_i.byte_off, 3'b000};
    assign data_algn = data_shft[`LSU_WORD_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Sign or zero extension
    ////////////////////////////////////////////////////////////////////////////
    logic sign_b;
    logic sign_h;

    // Fill bit, zero for unsigned loads
    assign sign_b = resp_slot_i.sgn & data_algn[7];
    assign sign_h = resp_slot_i.sgn & data_algn[15];

    always_comb begin
        case (resp_slot_i.size)
            LS_B: begin
                wb_o.data = {{(`LSU_WORD_W-8){sign_b}}, data_algn[7:0]};
            end
            LS_H: begin
                wb_o.data = {{(`LSU_WORD_W-16){sign_h}}, data_algn[15:0]};
            end
            // Full word, nothing to extend
            default: begin
                wb_o.data = data_algn;
            end
        endcase
        wb_o.itag = resp_slot_i.itag;
    end

    // Data is only meaningful for loads, stores just need the tag

endmodule

// File: logic/lsu_ctrl.sv
`timescale 1ns/100ps

module lsu_ctrl (
    input  logic clk_i,
    input  logic rst_i,
    input  logic lsu_req_i,
    input  logic misalign_i,
    input  logic dmem_req_rdy_i,
    input  logic dmem_resp_vld_i,
    input  logic issue_misalign_i,
    output logic lsu_rdy_o,
    output logic dmem_req_vld_o,
    output logic second_beat_o,
    output logic accept_o,
    output logic load_issue_o,
    output logic load_resp_o,
    output logic lsu_done_o
);
    import lsu_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////////////////////////////////////////
    lsu_cnt_t n_req_q;
    lsu_cnt_t n_resp_q;
    lsu_cnt_t n_req_n;
    lsu_cnt_t n_resp_n;
    lsu_cnt_t n_beats;
    logic     dmem_acc;
    logic     last_resp;

    // Final response of the current op arrives
    assign last_resp = dmem_resp_vld_i && (n_resp_q == lsu_cnt_t'(1));

    // No beats left, and no more than the arriving final response
    assign lsu_rdy_o = (n_req_q == '0) && ((n_resp_q == '0) || last_resp);
    assign accept_o  = lsu_req_i & lsu_rdy_o;

    // First beat bypassed in the accept cycle, then from the counter
    assign dmem_req_vld_o = accept_o || (n_req_q != '0);
    assign dmem_acc       = dmem_req_vld_o & dmem_req_rdy_i;

    // One or two beats per op
    assign n_beats = misalign_i ? lsu_cnt_t'(2) : lsu_cnt_t'(1);

    ////////////////////////////////////////////////////////////////////////////
    // Beat and response counters
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        n_req_n  = n_req_q;
        n_resp_n = n_resp_q;
        if (accept_o) begin
            // Less one if the first beat goes straight through
            n_req_n  = n_beats - lsu_cnt_t'(dmem_acc);
            // Old final response, if any, is consumed this cycle
            n_resp_n = n_beats;
        end
        else begin
            if (dmem_acc) begin
                n_req_n = n_req_q - lsu_cnt_t'(1);
            end
            if (dmem_resp_vld_i) begin
                n_resp_n = n_resp_q - lsu_cnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            n_req_q  <= '0;
            n_resp_q <= '0;
        end
        else begin
            n_req_q  <= n_req_n;
            n_resp_q <= n_resp_n;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Slot strobes and done
    ////////////////////////////////////////////////////////////////////////////

    // Upper word of a split access
    assign second_beat_o = issue_misalign_i && (n_req_q == lsu_cnt_t'(1));

    // Response slot from incoming request, nothing left to issue
    assign load_resp_o  = accept_o && (n_req_n == '0);
    // Response slot from issue slot, last beat taken later
    assign load_issue_o = !accept_o && (n_req_q != '0) && (n_req_n == '0);

    // Same cycle as the final response beat
    assign lsu_done_o = last_resp;

endmodule

// File: logic/lsu_top.sv
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_top (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // Execute side
    input  logic                   lsu_req_i,
    input  lsu_pkg::lsu_req_t      lsu_req_data_i,
    output logic                   lsu_rdy_o,
    // Data memory
    output logic                   dmem_req_vld_o,
    input  logic                   dmem_req_rdy_i,
    output lsu_pkg::dmem_req_t     dmem_req_o,
    input  logic                   dmem_resp_vld_i,
    input  logic [`LSU_WORD_W-1:0] dmem_resp_data_i,
    // Write-back
    output logic                   lsu_done_o,
    output lsu_pkg::lsu_wb_t       lsu_wb_o
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////////////////////////////////////////
    lsu_pkg::lsu_dec_t dec;
    lsu_pkg::lsu_dec_t issue_slot;
    lsu_pkg::lsu_dec_t resp_slot;
    logic              second_beat;
    logic              accept;
    logic              load_issue;
    logic              load_resp;

    // Decode incoming request
    lsu_addr_gen u_addr_gen (
        .req_i (lsu_req_data_i),
        .dec_o (dec)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////
    lsu_ctrl u_ctrl (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .lsu_req_i        (lsu_req_i),
        .misalign_i       (dec.misalign),
        .dmem_req_rdy_i   (dmem_req_rdy_i),
        .dmem_resp_vld_i  (dmem_resp_vld_i),
        .issue_misalign_i (issue_slot.misalign),
        .lsu_rdy_o        (lsu_rdy_o),
        .dmem_req_vld_o   (dmem_req_vld_o),
        .second_beat_o    (second_beat),
        .accept_o         (accept),
        .load_issue_o     (load_issue),
        .load_resp_o      (load_resp),
        .lsu_done_o       (lsu_done_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////
    lsu_req_regs u_req_regs (
        .clk_i        (clk_i),
        .dec_i        (dec),
        .load_issue_i (load_issue),
        .load_resp_i  (load_resp),
        .accept_i     (accept),
        .issue_o      (issue_slot),
        .resp_o       (resp_slot)
    );

    // Request beat toward memory
    lsu_store_align u_store_align (
        .issue_i       (issue_slot),
        .second_beat_i (second_beat),
        .dmem_req_o    (dmem_req_o)
    );

    // Response back to write-back
    lsu_load_align u_load_align (
        .clk_i            (clk_i),
        .resp_slot_i      (resp_slot),
        .dmem_resp_vld_i  (dmem_resp_vld_i),
        .dmem_resp_data_i (dmem_resp_data_i),
        .wb_o             (lsu_wb_o)
    );

endmodule

// File: test/lsu_mem_model.sv
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_mem_model (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   req_vld_i,
    output logic                   req_rdy_o,
    input  lsu_pkg::dmem_req_t     req_i,
    output logic                   resp_vld_o,
    output logic [`LSU_WORD_W-1:0] resp_data_o
);

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    // 64 words with address bits above 7 ignored
    localparam int words = 64;

    logic [`LSU_WORD_W-1:0] mem [words];
    integer                 seed;

    // Byte pattern that differs for every byte address
    function automatic logic [7:0] fill_byte(input logic [7:0] a);
        return a * 8'd29 + 8'h3c;
    endfunction

    initial begin
        seed = 32'h053582f5;
        for (int i = 0; i < words; i++) begin
            for (int k = 0; k < 4; k++) begin
                mem[i[5:0]][{k[1:0], 3'b000} +: 8] = fill_byte(8'(4 * i + k));
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Request and response
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk_i) begin
        logic [5:0] idx;
        idx = req_i.addr[7:2];
        if (rst_i) begin
            req_rdy_o   <= 1'b0;
            resp_vld_o  <= 1'b0;
            resp_data_o <= '0;
        end
        else begin
            // Ready about three cycles in four
            req_rdy_o  <= ($random(seed) & 3) != 0;
            // One response per accepted beat in the next cycle and in order
            resp_vld_o <= req_vld_i && req_rdy_o;
            if (req_vld_i && req_rdy_o) begin
                // Old contents go back before the store data lands
                resp_data_o <= mem[idx];
                if (req_i.w_en) begin
                    for (int k = 0; k < 4; k++) begin
                        if (req_i.be[k[1:0]]) begin
                            mem[idx][{k[1:0], 3'b000} +: 8] = req_i.w_data[{k[1:0], 3'b000} +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

// File: test/lsu_tb.sv
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_tb;
    import lsu_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Run length
    ////////////////////////////////////////////////////////////////////////////
    localparam int dir_ops    = 26;
    localparam int rnd_ops    = 200;
    // At most 20 cycles per op plus reset and drain
    localparam int max_cycles = (dir_ops + rnd_ops) * 20 + 100;

    // Expected write-back of one op
    typedef struct packed {
        logic                   load;
        logic [`LSU_WORD_W-1:0] data;
        logic [`LSU_ITAG_W-1:0] itag;
    } exp_wb_t;

    logic                   clk_i;
    logic                   rst_i;
    logic                   lsu_req;
    lsu_req_t               lsu_req_data;
    logic                   lsu_rdy;
    logic                   dmem_req_vld;
    logic                   dmem_req_rdy;
    dmem_req_t              dmem_req;
    logic                   dmem_resp_vld;
    logic [`LSU_WORD_W-1:0] dmem_resp_data;
    logic                   lsu_done;
    lsu_wb_t                lsu_wb;

    // Reference memory with one entry per byte of the model
    logic [7:0] ref_mem [256];
    exp_wb_t    exp_q [$];
    dmem_req_t  beat_q [$];
    logic       prev_vld;
    logic       prev_rdy;
    dmem_req_t  prev_req;
    int         n_ops;
    int         n_errors;
    int         cycle_cnt;
    int         test_no;
    integer     seed;

    lsu_top dut0 (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .lsu_req_i        (lsu_req),
        .lsu_req_data_i   (lsu_req_data),
        .lsu_rdy_o        (lsu_rdy),
        .dmem_req_vld_o   (dmem_req_vld),
        .dmem_req_rdy_i   (dmem_req_rdy),
        .dmem_req_o       (dmem_req),
        .dmem_resp_vld_i  (dmem_resp_vld),
        .dmem_resp_data_i (dmem_resp_data),
        .lsu_done_o       (lsu_done),
        .lsu_wb_o         (lsu_wb)
    );

    lsu_mem_model mem0 (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_vld_i   (dmem_req_vld),
        .req_rdy_o   (dmem_req_rdy),
        .req_i       (dmem_req),
        .resp_vld_o  (dmem_resp_vld),
        .resp_data_o (dmem_resp_data)
    );

    always #4 clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////////////////////
    // Reporting and reference model
    ////////////////////////////////////////////////////////////////////////////
    task automatic report_mismatch(input string name, input logic [71:0] exp,
                                   input logic [71:0] got);
        $display("Fail %s expected %0h got %0h at cycle %0d", name, exp, got, cycle_cnt);
        n_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("Problem at cycle %0d: %s", cycle_cnt, msg);
        n_errors++;
    endtask

    function automatic int size_bytes(input ls_size_e size);
        case (size)
            LS_B:    return 1;
            LS_H:    return 2;
            default: return 4;
        endcase
    endfunction

    // Byte enables widened to a bit mask
    function automatic logic [31:0] lane_mask(input logic [3:0] be);
        logic [31:0] m;
        for (int i = 0; i < 4; i++) begin
            m[{i[1:0], 3'b000} +: 8] = {8{be[i[1:0]]}};
        end
        return m;
    endfunction

    function automatic lsu_req_t make_req(input logic w_en, input logic [31:0] base,
                                          input logic [31:0] offset, input ls_size_e size,
                                          input logic sgn, input logic [31:0] w_data,
                                          input logic [2:0] itag);
        lsu_req_t r;
        r.w_en        = w_en;
        r.addr_base   = base;
        r.addr_offset = offset;
        r.size        = size;
        r.sgn         = sgn;
        r.w_data      = w_data;
        r.itag        = itag;
        return r;
    endfunction

    // One beat per touched word with each byte in the lane of its address
    function automatic void queue_beats(input lsu_req_t r);
        dmem_req_t   b [2];
        logic [31:0] ea;
        logic [31:0] a;
        logic        beat;
        logic        split;
        ea    = r.addr_base + r.addr_offset;
        split = 1'b0;
        for (int i = 0; i < 2; i++) begin
            b[i].addr   = {ea[31:2], 2'b00} + 32'(4 * i);
            b[i].w_en   = r.w_en;
            b[i].be     = '0;
            b[i].w_data = '0;
        end
        for (int k = 0; k < size_bytes(r.size); k++) begin
            a    = ea + k;
            beat = (a[31:2] != ea[31:2]);
            split |= beat;
            b[beat].be[a[1:0]] = 1'b1;
            b[beat].w_data[{a[1:0], 3'b000} +: 8] = r.w_data[{k[1:0], 3'b000} +: 8];
        end
        beat_q.push_back(b[0]);
        if (split) begin
            beat_q.push_back(b[1]);
        end
    endfunction

    // Load result from the reference with stores written in order
    function automatic exp_wb_t predict_op(input lsu_req_t r);
        exp_wb_t     e;
        logic [31:0] ea;
        logic [31:0] a;
        ea     = r.addr_base + r.addr_offset;
        e.load = !r.w_en;
        e.itag = r.itag;
        e.data = '0;
        for (int k = 0; k < size_bytes(r.size); k++) begin
            a = ea + k;
            e.data[{k[1:0], 3'b000} +: 8] = ref_mem[a[7:0]];
            if (r.w_en) begin
                ref_mem[a[7:0]] = r.w_data[{k[1:0], 3'b000} +: 8];
            end
        end
        if (r.sgn && r.size == LS_B && e.data[7]) begin
            e.data[31:8] = '1;
        end
        if (r.sgn && r.size == LS_H && e.data[15]) begin
            e.data[31:16] = '1;
        end
        return e;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks on every edge
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk_i) begin
        exp_wb_t   e;
        dmem_req_t b;
        if (!rst_i) begin
            // Write-back in order of acceptance
            if (lsu_done) begin
                assert (exp_q.size() != 0)
                    else report_problem("done pulse with no operation outstanding");
                if (exp_q.size() != 0) begin
                    e = exp_q.pop_front();
                    n_ops++;
                    assert (lsu_wb.itag == e.itag)
                        else report_mismatch("lsu_wb_o.itag", 72'(e.itag), 72'(lsu_wb.itag));
                    if (e.load) begin
                        assert (lsu_wb.data == e.data)
                            else report_mismatch("lsu_wb_o.data", 72'(e.data), 72'(lsu_wb.data));
                    end
                end
            end
            // Stalled beat must hold
            if (prev_vld && !prev_rdy) begin
                assert (dmem_req_vld)
                    else report_mismatch("dmem_req_vld_o", 72'(1), 72'(dmem_req_vld));
                assert (dmem_req == prev_req)
                    else report_mismatch("dmem_req_o", 72'(prev_req), 72'(dmem_req));
            end
            prev_vld = dmem_req_vld;
            prev_rdy = dmem_req_rdy;
            prev_req = dmem_req;
            // Beats of the last op still pending
            assert (beat_q.size() == 0 || !lsu_rdy)
                else report_mismatch("lsu_rdy_o", 72'(0), 72'(lsu_rdy));
            if (lsu_req && lsu_rdy) begin
                queue_beats(lsu_req_data);
                exp_q.push_back(predict_op(lsu_req_data));
            end
            if (dmem_req_vld && dmem_req_rdy) begin
                assert (beat_q.size() != 0)
                    else report_problem("memory beat issued that no request asked for");
                if (beat_q.size() != 0) begin
                    b = beat_q.pop_front();
                    assert (dmem_req.addr == b.addr)
                        else report_mismatch("dmem_req_o.addr", 72'(b.addr), 72'(dmem_req.addr));
                    assert (dmem_req.be == b.be)
                        else report_mismatch("dmem_req_o.be", 72'(b.be), 72'(dmem_req.be));
                    assert (dmem_req.w_en == b.w_en)
                        else report_mismatch("dmem_req_o.w_en", 72'(b.w_en), 72'(dmem_req.w_en));
                    if (b.w_en) begin
                        assert ((dmem_req.w_data & lane_mask(b.be)) == b.w_data)
                            else report_mismatch("dmem_req_o.w_data", 72'(b.w_data),
                                                 72'(dmem_req.w_data & lane_mask(b.be)));
                    end
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= max_cycles) begin
            $display("Run stopped after %0d cycles with operations still pending", cycle_cnt);
            $display("sim failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // Hold the request until the unit takes it
    task automatic issue_op(input lsu_req_t r);
        lsu_req      <= 1'b1;
        lsu_req_data <= r;
        do begin
            @(posedge clk_i);
        end while (!lsu_rdy);
        lsu_req <= 1'b0;
    endtask

    task automatic end_test(input string name);
        @(posedge clk_i);
        while (exp_q.size() != 0 || beat_q.size() != 0) begin
            @(posedge clk_i);
        end
        test_no++;
        $display("test %0d, %s: finished, %0d errors so far", test_no, name, n_errors);
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] base;
        logic [31:0] offset;
        logic [31:0] w_data;
        ls_size_e    sz;
        int          itag;
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        lsu_req      = 1'b0;
        lsu_req_data = '0;
        prev_vld     = 1'b0;
        prev_rdy     = 1'b0;
        prev_req     = '0;
        n_ops        = 0;
        n_errors     = 0;
        cycle_cnt    = 0;
        test_no      = 0;
        seed         = 32'h053582f5;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        @(posedge clk_i);
        for (int a = 0; a < 256; a++) begin
            ref_mem[a[7:0]] = mem0.mem[a[7:2]][{a[1:0], 3'b000} +: 8];
        end

        // Idle straight out of reset
        assert (lsu_rdy)
            else report_mismatch("lsu_rdy_o", 72'(1), 72'(lsu_rdy));
        assert (!lsu_done)
            else report_mismatch("lsu_done_o", 72'(0), 72'(lsu_done));
        assert (!dmem_req_vld)
            else report_mismatch("dmem_req_vld_o", 72'(0), 72'(dmem_req_vld));
        end_test("reset state");

        issue_op(make_req(1'b1, 32'h40, 32'h0, LS_W, 1'b0, 32'ha5c3_1e77, 3'd1));
        issue_op(make_req(1'b0, 32'h3c, 32'h4, LS_W, 1'b0, 32'h0, 3'd2));
        end_test("aligned word store then load");

        // Both sizes, both extensions, every offset
        itag = 0;
        for (int off = 0; off < 4; off++) begin
            for (int j = 0; j < 4; j++) begin
                sz = j[1] ? LS_H : LS_B;
                issue_op(make_req(1'b0, 32'h80, off, sz, j[0], 32'h0, 3'(itag)));
                itag++;
            end
        end
        end_test("byte and half-word loads");

        // Words at offsets 1 to 3 and a half-word at offset 3
        for (int i = 1; i < 5; i++) begin
            sz     = (i == 4) ? LS_H : LS_W;
            base   = 32'h20 + 32'(8 * i);
            offset = (i == 4) ? 32'd3 : i;
            rnd    = $random(seed);
            issue_op(make_req(1'b1, base, offset, sz, 1'b0, rnd, 3'(i)));
            issue_op(make_req(1'b0, base, offset, sz, 1'b1, 32'h0, 3'(i + 4)));
        end
        end_test("split accesses");

        for (int i = 0; i < rnd_ops; i++) begin
            rnd    = $random(seed);
            base   = $random(seed);
            offset = $random(seed);
            w_data = $random(seed);
            sz     = (rnd[1:0] == 2'b11) ? LS_W : ls_size_e'(rnd[1:0]);
            issue_op(make_req(rnd[2], base, offset, sz, rnd[3], w_data, 3'(i)));
            // Occasional gap between otherwise back-to-back requests
            if (rnd[5:4] == 2'b00) begin
                @(posedge clk_i);
            end
        end
        end_test("random mix with stalls");

        $display("%0d tests, %0d operations, %0d errors", test_no, n_ops, n_errors);
        if (n_errors == 0) begin
            $display("sim passed");
        end
        else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_addr_gen.sv
logic/lsu_req_regs.sv
logic/lsu_store_align.sv
logic/lsu_load_align.sv
logic/lsu_ctrl.sv
logic/lsu_top.sv
test/lsu_mem_model.sv
test/lsu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the load/store unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f all.f --top-module lsu_tb

./obj_dir/Vlsu_tb | tee sim.log

if grep -q "sim failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
